/* branch_pkg.sv */
package branch_pkg;

  ////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////

  // Data path width of the RV32 core
  localparam int xlen = 32;

  // Register index width, five bits address x0 to x31
  localparam int reg_idx_w = 5;

  // Architectural register count
  localparam int num_regs = 32;

  ////////////////////////////////////////
  // Branch kinds
  ////////////////////////////////////////

  // Encoded exactly as funct3 of the B-type instructions
  // 3'b010 and 3'b011 are unused and resolve as not taken
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_op_e;

  ////////////////////////////////////////
  // Forward selections
  ////////////////////////////////////////

  // Operand source for a branch in decode
  typedef enum logic [1:0] {
    fwd_ex = 2'b00,  // result of the instruction in execute
    fwd_wb = 2'b01,  // result of the instruction in write-back
    fwd_rf = 2'b11   // plain register file read
  } fwd_sel_e;

  // Execute unit that produced the execute result
  typedef enum logic [1:0] {
    ex_alu = 2'b00,
    ex_mul = 2'b01,
    ex_div = 2'b10
  } ex_src_e;

endpackage : branch_pkg

/* fwd_if.sv */
interface fwd_if;

  // Execute stage state of the older instruction
  logic                           ex_regwrite;
  logic                           ex_memread;
  logic [branch_pkg::reg_idx_w-1:0] ex_rd;

  // Candidate execute results
  logic [branch_pkg::xlen-1:0]    alu_res;
  logic [branch_pkg::xlen-1:0]    mul_res;
  logic [branch_pkg::xlen-1:0]    div_res;
  logic                           mul_ready;
  logic                           div_ready;

  // Write-back stage state
  logic                           wb_regwrite;
  logic [branch_pkg::reg_idx_w-1:0] wb_rd;
  logic [branch_pkg::xlen-1:0]    wb_res;

  // Top level drives everything from its ports
  modport source (
    output ex_regwrite, ex_memread, ex_rd,
    output alu_res, mul_res, div_res, mul_ready, div_ready,
    output wb_regwrite, wb_rd, wb_res
  );

  // Hazard detection only looks at write enables and destinations
  modport hazard (
    input ex_regwrite, ex_memread, ex_rd,
    input wb_regwrite, wb_rd
  );

  // Forward mux only looks at the data and the unit ready levels
  modport forward (
    input alu_res, mul_res, div_res, mul_ready, div_ready, wb_res
  );

endinterface : fwd_if

/* reg_file.sv */
module reg_file (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [branch_pkg::reg_idx_w-1:0] rs1_idx,
  input  logic [branch_pkg::reg_idx_w-1:0] rs2_idx,
  input  logic [branch_pkg::reg_idx_w-1:0] rd_idx,
  input  logic                           wr_en,
  input  logic [branch_pkg::xlen-1:0]    wr_data,
  output logic [branch_pkg::xlen-1:0]    rs1_data,
  output logic [branch_pkg::xlen-1:0]    rs2_data
);

  import branch_pkg::*;

  // Architectural registers, entry 0 is x0
  logic [xlen-1:0] regs [num_regs];

  // Write strobe with x0 filtered out
  logic            wr_ok;

  assign wr_ok = wr_en && (rd_idx != '0);

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  // Whole array cleared on reset
  // x0 is never written so it keeps its reset value of zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[rd_idx] <= wr_data;
    end
  end

  ////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////

  // Asynchronous reads
  // A same cycle write is not visible here, write-back forwarding covers it
  assign rs1_data = regs[rs1_idx];
  assign rs2_data = regs[rs2_idx];

  // x0 must read zero on both ports for the whole run
  a_x0_reads_zero : assert property (
    @(posedge clk) disable iff (!rst_n)
      ((rs1_idx == '0) |-> (rs1_data == '0)) and
      ((rs2_idx == '0) |-> (rs2_data == '0))
  ) else $error("reg_file: x0 read returned a nonzero value");

endmodule : reg_file

/* branch_hazard.sv */
module branch_hazard (
  input  logic [branch_pkg::reg_idx_w-1:0] rs1_idx,
  input  logic [branch_pkg::reg_idx_w-1:0] rs2_idx,
  input  logic                           branch_valid,
  fwd_if.hazard                          fwd,
  output branch_pkg::fwd_sel_e           sel_rs1,
  output branch_pkg::fwd_sel_e           sel_rs2,
  output logic                           stall
);

  import branch_pkg::*;

  // Index matches, never on x0
  logic rs1_ex_hit;
  logic rs2_ex_hit;
  logic rs1_wb_hit;
  logic rs2_wb_hit;

  // Execute holds a result that can be forwarded right now
  logic ex_fwd_ok;
  // Execute holds a load whose data is not there yet
  logic ex_load;

  ////////////////////////////////////////
  // Index compare
  ////////////////////////////////////////

  assign rs1_ex_hit = (rs1_idx == fwd.ex_rd) && (rs1_idx != '0);
  assign rs2_ex_hit = (rs2_idx == fwd.ex_rd) && (rs2_idx != '0);
  assign rs1_wb_hit = (rs1_idx == fwd.wb_rd) && (rs1_idx != '0);
  assign rs2_wb_hit = (rs2_idx == fwd.wb_rd) && (rs2_idx != '0);

  assign ex_fwd_ok = fwd.ex_regwrite && !fwd.ex_memread;
  assign ex_load   = fwd.ex_regwrite && fwd.ex_memread;

  ////////////////////////////////////////
  // Source selection
  ////////////////////////////////////////

  // Execute is the younger producer so it wins over write-back
  always_comb begin
    if (rs1_ex_hit && ex_fwd_ok) begin
      sel_rs1 = fwd_ex;
    end else if (rs1_wb_hit && fwd.wb_regwrite) begin
      sel_rs1 = fwd_wb;
    end else begin
      sel_rs1 = fwd_rf;
    end
  end

  // Same priority for the second operand
  always_comb begin
    if (rs2_ex_hit && ex_fwd_ok) begin
      sel_rs2 = fwd_ex;
    end else if (rs2_wb_hit && fwd.wb_regwrite) begin
      sel_rs2 = fwd_wb;
    end else begin
      sel_rs2 = fwd_rf;
    end
  end

  ////////////////////////////////////////
  // Load-use stall
  ////////////////////////////////////////

  // Hold the branch while a load in execute feeds either operand
  assign stall = branch_valid && ex_load && (rs1_ex_hit || rs2_ex_hit);

  // No stall without a branch in decode
  always_comb begin
    a_stall_needs_branch : assert (!stall || branch_valid)
      else $error("branch_hazard: stall raised with no valid branch");
  end

endmodule : branch_hazard

/* branch_forward.sv */
module branch_forward (
  fwd_if.forward                   fwd,
  input  branch_pkg::fwd_sel_e     sel_rs1,
  input  branch_pkg::fwd_sel_e     sel_rs2,
  input  logic [branch_pkg::xlen-1:0] rf_rs1,
  input  logic [branch_pkg::xlen-1:0] rf_rs2,
  output logic [branch_pkg::xlen-1:0] rs1_mod,
  output logic [branch_pkg::xlen-1:0] rs2_mod
);

  import branch_pkg::*;

  // Unit that owns the execute result this cycle
  ex_src_e         ex_src;
  // Result of the instruction in execute
  logic [xlen-1:0] ex_res;

  ////////////////////////////////////////
  // Execute unit pick
  ////////////////////////////////////////

  // A lone ready level picks its unit
  // Both high or both low falls back to the ALU
  always_comb begin
    if (fwd.div_ready && !fwd.mul_ready) begin
      ex_src = ex_div;
    end else if (fwd.mul_ready && !fwd.div_ready) begin
      ex_src = ex_mul;
    end else begin
      ex_src = ex_alu;
    end
  end

  always_comb begin
    case (ex_src)
      ex_div:  ex_res = fwd.div_res;
      ex_mul:  ex_res = fwd.mul_res;
      default: ex_res = fwd.alu_res;
    endcase
  end

  ////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////

  // rs1 from execute, write-back or the register file
  always_comb begin
    case (sel_rs1)
      fwd_ex:  rs1_mod = ex_res;
      fwd_wb:  rs1_mod = fwd.wb_res;
      default: rs1_mod = rf_rs1;
    endcase
  end

  // rs2 from execute, write-back or the register file
  always_comb begin
    case (sel_rs2)
      fwd_ex:  rs2_mod = ex_res;
      fwd_wb:  rs2_mod = fwd.wb_res;
      default: rs2_mod = rf_rs2;
    endcase
  end

endmodule : branch_forward

/* branch_resolve.sv */
module branch_resolve (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       branch_valid,
  input  logic                       stall,
  input  branch_pkg::branch_op_e     branch_op,
  input  logic [branch_pkg::xlen-1:0] pc,
  input  logic [branch_pkg::xlen-1:0] imm,
  input  logic [branch_pkg::xlen-1:0] rs1_mod,
  input  logic [branch_pkg::xlen-1:0] rs2_mod,
  output logic                       redirect,
  output logic [branch_pkg::xlen-1:0] redirect_pc
);

  import branch_pkg::*;

  // Branch leaves decode this cycle
  logic            accept;
  // Condition result for the current branch kind
  logic            taken;
  // Branch target
  logic [xlen-1:0] target;

  // Operand relations shared by the six kinds
  logic            op_eq;
  logic            op_lt_s;
  logic            op_lt_u;

  ////////////////////////////////////////
  // Condition and target
  ////////////////////////////////////////

  assign accept  = branch_valid && !stall;
  assign op_eq   = (rs1_mod == rs2_mod);
  assign op_lt_s = ($signed(rs1_mod) < $signed(rs2_mod));
  assign op_lt_u = (rs1_mod < rs2_mod);
  assign target  = pc + imm;

  // Greater-or-equal kinds are the inverse of less-than
  always_comb begin
    case (branch_op)
      beq:     taken = op_eq;
      bne:     taken = !op_eq;
      blt:     taken = op_lt_s;
      bge:     taken = !op_lt_s;
      bltu:    taken = op_lt_u;
      bgeu:    taken = !op_lt_u;
      default: taken = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Redirect register
  ////////////////////////////////////////

  // One cycle pulse per accepted taken branch
  // Target holds until the next taken branch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      redirect    <= 1'b0;
      redirect_pc <= '0;
    end else begin
      redirect <= accept && taken;
      if (accept && taken) begin
        redirect_pc <= target;
      end
    end
  end

  // A second redirect in a row needs a fresh accepted branch behind it
  a_redirect_pulse : assert property (
    @(posedge clk) disable iff (!rst_n)
      redirect |=> (!redirect || $past(accept))
  ) else $error("branch_resolve: redirect held without a new branch");

endmodule : branch_resolve

/* id_branch_unit.sv */
module id_branch_unit (
  input  logic                           clk,
  input  logic                           rst_n,
  // Branch in decode
  input  logic                           branch_valid,
  input  branch_pkg::branch_op_e         branch_op,
  input  logic [branch_pkg::reg_idx_w-1:0] rs1_idx,
  input  logic [branch_pkg::reg_idx_w-1:0] rs2_idx,
  input  logic [branch_pkg::xlen-1:0]    pc,
  input  logic [branch_pkg::xlen-1:0]    imm,
  // Execute stage
  input  logic                           ex_regwrite,
  input  logic                           ex_memread,
  input  logic [branch_pkg::reg_idx_w-1:0] ex_rd,
  input  logic [branch_pkg::xlen-1:0]    alu_res,
  input  logic [branch_pkg::xlen-1:0]    mul_res,
  input  logic [branch_pkg::xlen-1:0]    div_res,
  input  logic                           mul_ready,
  input  logic                           div_ready,
  // Write-back stage
  input  logic                           wb_regwrite,
  input  logic [branch_pkg::reg_idx_w-1:0] wb_rd,
  input  logic [branch_pkg::xlen-1:0]    wb_res,
  // Results
  output logic                           stall,
  output logic                           redirect,
  output logic [branch_pkg::xlen-1:0]    redirect_pc
);

  import branch_pkg::*;

  fwd_sel_e        sel_rs1;
  fwd_sel_e        sel_rs2;
  logic [xlen-1:0] rf_rs1;
  logic [xlen-1:0] rf_rs2;
  logic [xlen-1:0] rs1_mod;
  logic [xlen-1:0] rs2_mod;

  ////////////////////////////////////////
  // Pipeline state bundle
  ////////////////////////////////////////

  fwd_if i_fwd ();

  assign i_fwd.ex_regwrite = ex_regwrite;
  assign i_fwd.ex_memread  = ex_memread;
  assign i_fwd.ex_rd       = ex_rd;
  assign i_fwd.alu_res     = alu_res;
  assign i_fwd.mul_res     = mul_res;
  assign i_fwd.div_res     = div_res;
  assign i_fwd.mul_ready   = mul_ready;
  assign i_fwd.div_ready   = div_ready;
  assign i_fwd.wb_regwrite = wb_regwrite;
  assign i_fwd.wb_rd       = wb_rd;
  assign i_fwd.wb_res      = wb_res;

  ////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////

  // Write port is fed straight from write-back
  reg_file i_reg_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .rd_idx   (wb_rd),
    .wr_en    (wb_regwrite),
    .wr_data  (wb_res),
    .rs1_data (rf_rs1),
    .rs2_data (rf_rs2)
  );

  branch_hazard i_branch_hazard (
    .rs1_idx      (rs1_idx),
    .rs2_idx      (rs2_idx),
    .branch_valid (branch_valid),
    .fwd          (i_fwd),
    .sel_rs1      (sel_rs1),
    .sel_rs2      (sel_rs2),
    .stall        (stall)
  );

  branch_forward i_branch_forward (
    .fwd     (i_fwd),
    .sel_rs1 (sel_rs1),
    .sel_rs2 (sel_rs2),
    .rf_rs1  (rf_rs1),
    .rf_rs2  (rf_rs2),
    .rs1_mod (rs1_mod),
    .rs2_mod (rs2_mod)
  );

  branch_resolve i_branch_resolve (
    .clk          (clk),
    .rst_n        (rst_n),
    .branch_valid (branch_valid),
    .stall        (stall),
    .branch_op    (branch_op),
    .pc           (pc),
    .imm          (imm),
    .rs1_mod      (rs1_mod),
    .rs2_mod      (rs2_mod),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc)
  );

endmodule : id_branch_unit

/* tb_id_branch_unit.sv */
module tb_id_branch_unit;

  timeunit 1ns;
  timeprecision 100ps;

  import branch_pkg::*;

  // Test length, the timeout is derived from it
  localparam int n_directed = 60;
  localparam int n_random   = 300;
  localparam int max_cycles = 400 + 10 * (n_directed + n_random);

  // Expected response of one decode cycle
  typedef struct packed {
    logic            stall;
    logic            taken;
    logic [xlen-1:0] target;
  } expect_t;

  logic                 clk;
  logic                 rst_n;
  logic                 branch_valid;
  branch_op_e           branch_op;
  logic [reg_idx_w-1:0] rs1_idx;
  logic [reg_idx_w-1:0] rs2_idx;
  logic [xlen-1:0]      pc;
  logic [xlen-1:0]      imm;
  logic                 ex_regwrite;
  logic                 ex_memread;
  logic [reg_idx_w-1:0] ex_rd;
  logic [xlen-1:0]      alu_res;
  logic [xlen-1:0]      mul_res;
  logic [xlen-1:0]      div_res;
  logic                 mul_ready;
  logic                 div_ready;
  logic                 wb_regwrite;
  logic [reg_idx_w-1:0] wb_rd;
  logic [xlen-1:0]      wb_res;
  logic                 stall;
  logic                 redirect;
  logic [xlen-1:0]      redirect_pc;

  // Shadow copy of the architectural registers
  logic [xlen-1:0]      shadow [num_regs];

  id_branch_unit i_dut (.*);

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Execute beats write-back, x0 never forwards, loads never forward
  function automatic logic [xlen-1:0] pick_operand(input logic [reg_idx_w-1:0] idx,
                                                   input logic [xlen-1:0] ex_val);
    if (idx != '0 && idx == ex_rd && ex_regwrite && !ex_memread) begin
      return ex_val;
    end
    if (idx != '0 && idx == wb_rd && wb_regwrite) begin
      return wb_res;
    end
    return shadow[idx];
  endfunction

  function automatic expect_t predict_branch();
    expect_t         e;
    logic [xlen-1:0] ex_val;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    // A lone ready level names the unit, anything else means the ALU
    if (div_ready && !mul_ready) begin
      ex_val = div_res;
    end else if (mul_ready && !div_ready) begin
      ex_val = mul_res;
    end else begin
      ex_val = alu_res;
    end
    a = pick_operand(rs1_idx, ex_val);
    b = pick_operand(rs2_idx, ex_val);
    e.stall = branch_valid && ex_regwrite && ex_memread &&
              ((rs1_idx != '0 && rs1_idx == ex_rd) || (rs2_idx != '0 && rs2_idx == ex_rd));
    case (branch_op)
      beq:     e.taken = (a == b);
      bne:     e.taken = (a != b);
      blt:     e.taken = ($signed(a) < $signed(b));
      bge:     e.taken = ($signed(a) >= $signed(b));
      bltu:    e.taken = (a < b);
      bgeu:    e.taken = (a >= b);
      default: e.taken = 1'b0;
    endcase
    e.target = pc + imm;
    return e;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail time %0t signal %s expected %b actual %b", $time, name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_word(input string name, input logic [xlen-1:0] exp,
                            input logic [xlen-1:0] act);
    if (act !== exp) begin
      $display("Fail time %0t signal %s expected %h actual %h", $time, name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Sampled 1 ns after the rising edge, inputs still hold until the falling edge
  // redirect then shows the branch whose inputs are still applied
  initial begin : compare_proc
    expect_t         e;
    logic            exp_redirect;
    logic [xlen-1:0] exp_pc;
    exp_pc = '0;
    shadow = '{default: '0};
    forever begin
      @(posedge clk);
      #1;
      if (!rst_n) begin
        exp_pc = '0;
        shadow = '{default: '0};
        check_level("redirect", 1'b0, redirect);
        check_word("redirect_pc", exp_pc, redirect_pc);
      end else begin
        // Shadow still holds the pre-edge values the DUT compared against
        e = predict_branch();
        exp_redirect = branch_valid && !e.stall && e.taken;
        if (exp_redirect) begin
          exp_pc = e.target;
        end
        check_level("stall", e.stall, stall);
        check_level("redirect", exp_redirect, redirect);
        check_word("redirect_pc", exp_pc, redirect_pc);
        if (wb_regwrite && wb_rd != '0) begin
          shadow[wb_rd] = wb_res;
        end
      end
    end
  end

  // Watchdog
  initial begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout, stimulus did not finish within %0d cycles", max_cycles);
    $display("FAIL: see errors above");
    $fatal(1, "timeout");
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Idle pipeline, data values are left as they are
  task automatic clear_pipe();
    branch_valid = 1'b0;
    ex_regwrite  = 1'b0;
    ex_memread   = 1'b0;
    ex_rd        = '0;
    mul_ready    = 1'b0;
    div_ready    = 1'b0;
    wb_regwrite  = 1'b0;
    wb_rd        = '0;
  endtask

  task automatic next_cycle();
    @(negedge clk);
    clear_pipe();
  endtask

  task automatic set_branch(input branch_op_e op, input logic [reg_idx_w-1:0] r1,
                            input logic [reg_idx_w-1:0] r2, input logic [xlen-1:0] p,
                            input logic [xlen-1:0] im);
    branch_valid = 1'b1;
    branch_op    = op;
    rs1_idx      = r1;
    rs2_idx      = r2;
    pc           = p;
    imm          = im;
  endtask

  task automatic set_ex(input logic [reg_idx_w-1:0] rd, input logic load,
                        input logic [xlen-1:0] alu, input logic [xlen-1:0] mul,
                        input logic [xlen-1:0] div, input logic mrdy, input logic drdy);
    ex_regwrite = 1'b1;
    ex_memread  = load;
    ex_rd       = rd;
    alu_res     = alu;
    mul_res     = mul;
    div_res     = div;
    mul_ready   = mrdy;
    div_ready   = drdy;
  endtask

  task automatic set_wb(input logic [reg_idx_w-1:0] rd, input logic [xlen-1:0] val);
    wb_regwrite = 1'b1;
    wb_rd       = rd;
    wb_res      = val;
  endtask

  task automatic write_reg(input logic [reg_idx_w-1:0] rd, input logic [xlen-1:0] val);
    next_cycle();
    set_wb(rd, val);
  endtask

  // One branch of each kind on the same operand pair
  task automatic branch_all_kinds(input logic [reg_idx_w-1:0] r1,
                                  input logic [reg_idx_w-1:0] r2,
                                  input logic [xlen-1:0] p, input logic [xlen-1:0] im);
    branch_op_e op;
    op = op.first();
    repeat (6) begin
      next_cycle();
      set_branch(op, r1, r2, p, im);
      op = op.next();
    end
  endtask

  // Small index range so that hazards come up often
  function automatic logic [reg_idx_w-1:0] rand_idx();
    logic [31:0] r;
    r = $urandom;
    return {2'b00, r[2:0]};
  endfunction

  // Signed and unsigned edge values mixed into plain random words
  function automatic logic [xlen-1:0] rand_word();
    logic [31:0] sel;
    logic [31:0] val;
    sel = $urandom;
    val = $urandom;
    case (sel[2:0])
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'h8000_0000;
      3'd2:    return 32'h7fff_ffff;
      3'd3:    return 32'hffff_ffff;
      default: return val;
    endcase
  endfunction

  task automatic random_cycle();
    logic [31:0] r;
    branch_op_e  op;
    r = $urandom;
    op = op.first();
    repeat (r % 6) op = op.next();
    branch_valid = (r[9:8] != 2'b00);
    branch_op    = op;
    rs1_idx      = rand_idx();
    rs2_idx      = rand_idx();
    pc           = $urandom;
    imm          = rand_word();
    ex_regwrite  = r[10];
    ex_memread   = (r[12:11] == 2'b00);
    ex_rd        = rand_idx();
    alu_res      = rand_word();
    mul_res      = rand_word();
    div_res      = rand_word();
    mul_ready    = r[13];
    div_ready    = r[14];
    wb_regwrite  = r[15];
    wb_rd        = rand_idx();
    wb_res       = rand_word();
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : stimulus
    void'($urandom(20028));
    rst_n = 1'b0;
    clear_pipe();
    branch_op = beq;
    rs1_idx   = '0;
    rs2_idx   = '0;
    pc        = '0;
    imm       = '0;
    alu_res   = '0;
    mul_res   = '0;
    div_res   = '0;
    wb_res    = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // Register file path with signed and unsigned edge values
    write_reg(5'd1, 32'd5);
    write_reg(5'd2, 32'hffff_fffd);
    write_reg(5'd3, 32'h8000_0000);
    write_reg(5'd4, 32'h7fff_ffff);
    write_reg(5'd5, 32'd5);
    write_reg(5'd7, 32'd20);
    branch_all_kinds(5'd1, 5'd5, 32'h0000_0100, 32'h0000_0040);
    branch_all_kinds(5'd1, 5'd2, 32'h0000_2000, 32'hffff_fff8);
    branch_all_kinds(5'd3, 5'd4, 32'h0001_0000, 32'h0000_0800);
    branch_all_kinds(5'd4, 5'd3, 32'hffff_fff0, 32'h0000_0020);
    branch_all_kinds(5'd2, 5'd1, 32'h0000_0404, 32'hffff_f000);

    // Execute forwarding against x7
    // Only the unit named by the ready levels carries the matching value
    for (int k = 0; k < 4; k++) begin
      next_cycle();
      set_ex(5'd6, 1'b0, (k == 0 || k == 3) ? 32'd20 : 32'd10,
             (k == 1) ? 32'd20 : 32'd11, (k == 2) ? 32'd20 : 32'd12, k[0], k[1]);
      set_branch(beq, 5'd6, 5'd7, 32'h0000_3000 + 32'(k * 16), 32'h0000_0010);
    end

    // Write-back alone, then execute over write-back
    next_cycle();
    set_wb(5'd8, 32'd20);
    set_branch(beq, 5'd8, 5'd7, 32'h0000_4000, 32'h0000_0024);
    next_cycle();
    set_ex(5'd8, 1'b0, 32'd5, 32'd0, 32'd0, 1'b0, 1'b0);
    set_wb(5'd8, 32'd20);
    set_branch(beq, 5'd8, 5'd1, 32'h0000_5000, 32'h0000_0030);

    // Load-use, branch and pipeline held while stalled
    repeat (3) begin
      next_cycle();
      set_ex(5'd9, 1'b1, 32'h0000_dead, 32'd0, 32'd0, 1'b0, 1'b0);
      set_branch(blt, 5'd1, 5'd9, 32'h0000_6000, 32'h0000_0100);
    end
    // Loaded value now forwards from write-back
    next_cycle();
    set_wb(5'd9, 32'd100);
    set_branch(blt, 5'd1, 5'd9, 32'h0000_6000, 32'h0000_0100);

    // x0 as a destination is ignored everywhere
    // x6 was never written, so it equals x0 only while x0 stays zero
    next_cycle();
    set_ex(5'd0, 1'b0, 32'd99, 32'd0, 32'd0, 1'b0, 1'b0);
    set_wb(5'd0, 32'd77);
    set_branch(beq, 5'd0, 5'd6, 32'h0000_7000, 32'h0000_0008);
    next_cycle();
    set_ex(5'd0, 1'b1, 32'd99, 32'd0, 32'd0, 1'b0, 1'b0);
    set_branch(bne, 5'd0, 5'd0, 32'h0000_7100, 32'h0000_0008);
    next_cycle();
    set_branch(beq, 5'd0, 5'd6, 32'h0000_7200, 32'h0000_000c);

    // Random back-to-back traffic
    for (int i = 0; i < n_random; i++) begin
      @(negedge clk);
      if (stall) begin
        // Hold one more cycle, then the load reaches write-back
        @(negedge clk);
        wb_regwrite = 1'b1;
        wb_rd       = ex_rd;
        wb_res      = rand_word();
        ex_regwrite = 1'b0;
        ex_memread  = 1'b0;
      end else begin
        random_cycle();
      end
    end

    // Drain the last redirect
    next_cycle();
    repeat (3) @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule : tb_id_branch_unit

/* verilog.f */
branch_pkg.sv
fwd_if.sv
reg_file.sv
branch_hazard.sv
branch_forward.sv
branch_resolve.sv
id_branch_unit.sv
tb_id_branch_unit.sv

/* Makefile */
# Verilator build for the decode stage branch unit

VERILATOR ?= verilator
TOP       ?= tb_id_branch_unit
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a nonzero exit status
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
